//--- src.f
+incdir+include
rtl/lidar_pkg.sv
rtl/uart_rx.sv
rtl/scan_frame_parser.sv
rtl/scan_extrema.sv
rtl/angle_interp.sv
rtl/lidar_scan_top.sv
testbench/lidar_scan_checker.sv
testbench/lidar_scan_tb.sv

//--- testbench/lidar_scan_tb.sv
`default_nettype none

`include "lidar_config.svh"

module lidar_scan_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lidar_pkg::*;

    localparam int  CLK_PERIOD  = 100;
    localparam int  TOTAL_BYTES = 160;                      // Every byte the tests send
    localparam real WATCHDOG_NS = TOTAL_BYTES * 10.0 * `LIDAR_CLKS_PER_BIT * CLK_PERIOD * 1.2;
    localparam int  DONE_WAIT   = 4 * `LIDAR_CLKS_PER_BIT;  // Cycles allowed after last byte

    logic        clk;
    logic        rst;
    logic        rx;
    dist_t       max_dist;
    dist_t       min_dist;
    logic [15:0] max_idx;
    logic [15:0] min_idx;
    alert_t      obs_alert;
    angle_t      max_angle;
    angle_t      min_angle;
    logic        angle_done;

    int          error_count;
    int          check_count;
    int          done_count;        // angle_done pulses seen so far
    dist_t       samples [0:127];   // Distances of the next frame
    dist_t       exp_max;
    dist_t       exp_min;
    int          exp_max_idx;
    int          exp_min_idx;
    alert_t      exp_alert;
    angle_t      exp_max_angle;
    angle_t      exp_min_angle;

    lidar_scan_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .max_dist   (max_dist),
        .min_dist   (min_dist),
        .max_idx    (max_idx),
        .min_idx    (min_idx),
        .obs_alert  (obs_alert),
        .max_angle  (max_angle),
        .min_angle  (min_angle),
        .angle_done (angle_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Counted on the falling edge away from register updates
    always @(negedge clk) begin
        if (angle_done === 1'b1)
            done_count++;
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    // 8N1 character with the start bit first and data LSB first
    task automatic send_byte(input byte_t data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (`LIDAR_CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // Expected angle at one index by true division
    function automatic angle_t expected_angle(input int ct, input int fsa, input int lsa,
                                              input int idx);
        int span;
        int div;
        int sum;
        span = (lsa >= fsa) ? lsa - fsa : lsa + `LIDAR_FULL_CIRCLE - fsa;
        div  = 1;
        for (int p = 1; p <= 128; p = p * 2)
            if (ct == p) div = p;            // Only powers of two divide
        sum = fsa + idx * (span / div);
        if (sum >= `LIDAR_FULL_CIRCLE)
            sum = sum - `LIDAR_FULL_CIRCLE;   // Once only
        return angle_t'(sum);
    endfunction

    // Reference statistics for samples[0..ct-1]
    task automatic model_frame(input int ct, input angle_t fsa, input angle_t lsa);
        exp_max     = '0;
        exp_min     = '1;
        exp_max_idx = 0;
        exp_min_idx = 0;
        exp_alert   = '0;
        for (int i = 0; i < ct; i++) begin
            if (samples[i] > exp_max) begin
                exp_max     = samples[i];
                exp_max_idx = i;
            end
            if (samples[i] < exp_min) begin
                exp_min     = samples[i];
                exp_min_idx = i;
            end
            if (i < `LIDAR_ALERT_BITS && samples[i] < `LIDAR_ALERT_THRESH)
                exp_alert[i] = 1'b1;
        end
        exp_max_angle = expected_angle(ct, fsa, lsa, exp_max_idx);
        exp_min_angle = expected_angle(ct, fsa, lsa, exp_min_idx);
    endtask

    task automatic wait_angle_done(input string test_name, input int count_before);
        int cycles;
        cycles = 0;
        while (done_count == count_before && cycles < DONE_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (done_count == count_before) begin
            error_count++;
            $display("Error in %s: angle_done never came after the frame was sent", test_name);
        end
        @(negedge clk);   // Levels are stable here
    endtask

    // Send one full frame and compare every result with the model
    task automatic run_frame(input string test_name, input int ct,
                             input angle_t fsa, input angle_t lsa);
        int count_before;
        model_frame(ct, fsa, lsa);
        count_before = done_count;
        send_byte(`LIDAR_HDR1);
        send_byte(`LIDAR_HDR2);
        send_byte(byte_t'(ct));
        send_byte(fsa[7:0]);
        send_byte(fsa[15:8]);
        send_byte(lsa[7:0]);
        send_byte(lsa[15:8]);
        for (int i = 0; i < ct; i++) begin
            send_byte(samples[i][7:0]);     // Low byte first
            send_byte(samples[i][15:8]);
        end
        wait_angle_done(test_name, count_before);
        check_value(test_name, "max_dist", exp_max, max_dist);
        check_value(test_name, "min_dist", exp_min, min_dist);
        check_value(test_name, "max_idx", exp_max_idx, max_idx);
        check_value(test_name, "min_idx", exp_min_idx, min_idx);
        check_value(test_name, "obs_alert", exp_alert, obs_alert);
        check_value(test_name, "max_angle", exp_max_angle, max_angle);
        check_value(test_name, "min_angle", exp_min_angle, min_angle);
    endtask

    task automatic reset_state_test();
        @(negedge clk);
        check_value("reset_state", "angle_done", 0, angle_done);
        check_value("reset_state", "min_dist", 16'hFFFF, min_dist);
        check_value("reset_state", "max_dist", 0, max_dist);
        check_value("reset_state", "max_idx", 0, max_idx);
        check_value("reset_state", "min_idx", 0, min_idx);
        check_value("reset_state", "obs_alert", 0, obs_alert);
        check_value("reset_state", "max_angle", 0, max_angle);
        check_value("reset_state", "min_angle", 0, min_angle);
    endtask

    task automatic extrema_test();
        for (int i = 0; i < 8; i++)
            samples[i] = dist_t'($urandom_range(60000, 10));
        samples[2] = 16'hFFF0;   // Max tie where index 2 wins
        samples[6] = 16'hFFF0;
        samples[3] = 16'h0005;   // Min tie at 3 and 7
        samples[7] = 16'h0005;
        run_frame("extrema_ct8", 8, 16'd4500, 16'd9300);
        check_value("extrema_ct8", "max_idx tie", 2, max_idx);
        check_value("extrema_ct8", "min_idx tie", 3, min_idx);
    endtask

    task automatic angle_test();
        samples[0] = 16'd3000;
        samples[1] = 16'd2500;   // Min in both frames at index 1 or 2
        samples[2] = 16'd2800;
        samples[3] = 16'd4200;   // Max
        run_frame("angle_forward", 4, 16'd1000, 16'd9000);
        check_value("angle_forward", "max_angle", 7000, max_angle);
        check_value("angle_forward", "min_angle", 3000, min_angle);
        samples[1] = 16'd2900;
        samples[2] = 16'd800;
        run_frame("angle_wrap", 4, 16'd35000, 16'd2000);   // Span crosses zero
        check_value("angle_wrap", "max_angle", 1250, max_angle);
        check_value("angle_wrap", "min_angle", 500, min_angle);
    endtask

    task automatic header_sync_test();
        int count_before;
        count_before = done_count;
        send_byte(8'h13);        // Noise before any header
        send_byte(8'h00);
        send_byte(8'h55);        // Lone 0x55 then a wrong byte and a stray 0xAA
        send_byte(8'h37);
        send_byte(8'hAA);
        send_byte(8'h55);        // Becomes 0x55 0x55 0xAA
        for (int i = 0; i < 4; i++)
            samples[i] = dist_t'($urandom_range(60000, 10));
        run_frame("header_sync", 4, 16'd12000, 16'd12400);
        repeat (2 * `LIDAR_CLKS_PER_BIT) @(posedge clk);
        check_value("header_sync", "angle_done pulses", 1, done_count - count_before);
    endtask

    task automatic alert_test();
        for (int i = 0; i < 32; i++)
            samples[i] = dist_t'($urandom_range(60000, `LIDAR_ALERT_THRESH));
        samples[3]  = 16'd500;
        samples[20] = 16'd300;   // Near but past the mask
        run_frame("alert_ct32", 32, 16'd0, 16'd35000);
        check_value("alert_ct32", "obs_alert bit 3 only", 16'h0008, obs_alert);
        for (int i = 0; i < 4; i++)
            samples[i] = dist_t'($urandom_range(60000, `LIDAR_ALERT_THRESH));
        run_frame("alert_clear", 4, 16'd100, 16'd900);
        check_value("alert_clear", "obs_alert", 0, obs_alert);
    endtask

    initial begin
        rst         = 1'b1;
        rx          = 1'b1;   // Line idles high
        error_count = 0;
        check_count = 0;
        void'($urandom(72726));
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_state_test();
        extrema_test();
        angle_test();
        header_sync_test();
        alert_test();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Serial time of all frames plus a fifth more
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run hung and did not finish its frames in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/lidar_scan_checker.sv
`default_nettype none

module lidar_scan_checker (
    input logic clk,
    input logic rst,
    input logic byte_valid,     // From uart_rx
    input logic sample_valid,   // From the parser
    input logic frame_done,
    input logic angle_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Result strobe lasts one cycle
    done_single_a: assert property (@(posedge clk) disable iff (rst)
        angle_done |=> !angle_done)
        else $error("angle_done stayed high for two cycles");

    // Two delay flops then the latch and compute cycles
    done_latency_a: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> ##4 angle_done)
        else $error("angle_done missing 4 cycles after frame_done");

    done_source_a: assert property (@(posedge clk) disable iff (rst)
        angle_done |-> $past(frame_done, 4))
        else $error("angle_done without a frame_done 4 cycles earlier");

    // Strobes stay low after the first reset edge
    reset_quiet_a: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !(sample_valid || byte_valid))
        else $error("strobe active while reset is held");

endmodule

bind lidar_scan_top lidar_scan_checker chk_i (
    .clk          (clk),
    .rst          (rst),
    .byte_valid   (byte_valid),
    .sample_valid (sample_valid),
    .frame_done   (frame_done),
    .angle_done   (angle_done)
);

`default_nettype wire

//--- rtl/lidar_scan_top.sv
`default_nettype none

module lidar_scan_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,          // Serial scan data from the sensor
    output lidar_pkg::dist_t  max_dist,
    output lidar_pkg::dist_t  min_dist,
    output lidar_pkg::idx_t   max_idx,
    output lidar_pkg::idx_t   min_idx,
    output lidar_pkg::alert_t obs_alert,
    output lidar_pkg::angle_t max_angle,
    output lidar_pkg::angle_t min_angle,
    output logic              angle_done
);
    import lidar_pkg::*;

    byte_t  rx_byte;
    logic   byte_valid;
    ct_t    ct;
    angle_t fsa;
    angle_t lsa;
    logic   start_frame;
    logic   sample_valid;
    dist_t  sample_value;
    idx_t   sample_idx;
    logic   frame_done;

    // Stage 1 turns the serial line into bytes
    uart_rx rx_i (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    // Stage 2 splits bytes into frame fields and samples
    scan_frame_parser parser_i (
        .clk          (clk),
        .rst          (rst),
        .rx_byte      (rx_byte),
        .byte_valid   (byte_valid),
        .ct           (ct),
        .fsa          (fsa),
        .lsa          (lsa),
        .start_frame  (start_frame),
        .sample_valid (sample_valid),
        .sample_value (sample_value),
        .sample_idx   (sample_idx),
        .frame_done   (frame_done)
    );

    // Stage 3
    scan_extrema extrema_i (
        .clk          (clk),
        .rst          (rst),
        .start_frame  (start_frame),
        .sample_valid (sample_valid),
        .sample_value (sample_value),
        .sample_idx   (sample_idx),
        .max_dist     (max_dist),
        .min_dist     (min_dist),
        .max_idx      (max_idx),
        .min_idx      (min_idx),
        .obs_alert    (obs_alert)
    );

    // Stage 4 runs while the next frame may already be arriving
    angle_interp angle_i (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .fsa        (fsa),
        .lsa        (lsa),
        .ct         (ct),
        .max_idx    (max_idx),
        .min_idx    (min_idx),
        .max_angle  (max_angle),
        .min_angle  (min_angle),
        .angle_done (angle_done)
    );

endmodule

`default_nettype wire

//--- rtl/angle_interp.sv
`default_nettype none

`include "lidar_config.svh"

module angle_interp (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_done,
    input  lidar_pkg::angle_t fsa,
    input  lidar_pkg::angle_t lsa,
    input  lidar_pkg::ct_t    ct,
    input  lidar_pkg::idx_t   max_idx,
    input  lidar_pkg::idx_t   min_idx,
    output lidar_pkg::angle_t max_angle,
    output lidar_pkg::angle_t min_angle,
    output logic              angle_done
);
    import lidar_pkg::*;

    logic        done_d1;
    logic        start;          // Two cycles after frame_done once the extrema are stable
    logic        calc_pending;
    angle_t      fsa_r;
    idx_t        max_idx_r;
    idx_t        min_idx_r;
    logic [31:0] span_now;
    logic [31:0] span_r;
    logic [2:0]  shift_r;        // log2(CT)
    logic [31:0] step;
    logic [47:0] max_sum;
    logic [47:0] min_sum;

    // Shift amount for a power-of-two CT and zero for any other CT
    function automatic logic [2:0] ct_shift(input ct_t n);
        case (n)
            8'd2:    return 3'd1;
            8'd4:    return 3'd2;
            8'd8:    return 3'd3;
            8'd16:   return 3'd4;
            8'd32:   return 3'd5;
            8'd64:   return 3'd6;
            8'd128:  return 3'd7;
            default: return 3'd0;
        endcase
    endfunction

    // One subtraction of a full turn and then the low 16 bits
    function automatic angle_t wrap_circle(input logic [47:0] sum);
        if (sum >= 48'(`LIDAR_FULL_CIRCLE))
            return angle_t'(sum - 48'(`LIDAR_FULL_CIRCLE));
        return angle_t'(sum);
    endfunction

    // Span crosses zero when LSA is below FSA
    assign span_now = (lsa >= fsa) ? 32'(lsa) - 32'(fsa)
                                   : 32'(lsa) + 32'(`LIDAR_FULL_CIRCLE) - 32'(fsa);

    assign step    = span_r >> shift_r;
    assign max_sum = 48'(step) * 48'(max_idx_r) + 48'(fsa_r);
    assign min_sum = 48'(step) * 48'(min_idx_r) + 48'(fsa_r);

    // Operands latched at the start
    always_ff @(posedge clk) begin
        if (start) begin
            fsa_r     <= fsa;
            max_idx_r <= max_idx;
            min_idx_r <= min_idx;
            span_r    <= span_now;
            shift_r   <= ct_shift(ct);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_d1      <= 1'b0;
            start        <= 1'b0;
            calc_pending <= 1'b0;
            max_angle    <= '0;
            min_angle    <= '0;
            angle_done   <= 1'b0;
        end else begin
            done_d1      <= frame_done;
            start        <= done_d1;
            calc_pending <= start;
            angle_done   <= calc_pending;    // Lands 4 cycles after frame_done
            if (calc_pending) begin
                max_angle <= wrap_circle(max_sum);
                min_angle <= wrap_circle(min_sum);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/scan_extrema.sv
`default_nettype none

`include "lidar_config.svh"

module scan_extrema (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_frame,
    input  logic              sample_valid,
    input  lidar_pkg::dist_t  sample_value,
    input  lidar_pkg::idx_t   sample_idx,
    output lidar_pkg::dist_t  max_dist,
    output lidar_pkg::dist_t  min_dist,
    output lidar_pkg::idx_t   max_idx,
    output lidar_pkg::idx_t   min_idx,
    output lidar_pkg::alert_t obs_alert
);
    import lidar_pkg::*;

    localparam int SEL_W = $clog2(`LIDAR_ALERT_BITS);

    logic   is_near;
    logic   in_mask;     // Index falls inside the alert mask
    alert_t alert_bit;

    assign is_near   = sample_value < dist_t'(`LIDAR_ALERT_THRESH);
    assign in_mask   = sample_idx < idx_t'(`LIDAR_ALERT_BITS);
    assign alert_bit = (is_near && in_mask) ? alert_t'(1) << sample_idx[SEL_W-1:0] : '0;

    always_ff @(posedge clk) begin
        if (rst || start_frame) begin    // Fresh statistics per frame
            max_dist  <= '0;
            min_dist  <= '1;
            max_idx   <= '0;
            min_idx   <= '0;
            obs_alert <= '0;
        end else if (sample_valid) begin
            // Strict compares keep the earliest index on ties
            if (sample_value > max_dist) begin
                max_dist <= sample_value;
                max_idx  <= sample_idx;
            end
            if (sample_value < min_dist) begin
                min_dist <= sample_value;
                min_idx  <= sample_idx;
            end
            obs_alert <= obs_alert | alert_bit;   // Sticky until next frame
        end
    end

endmodule

`default_nettype wire

//--- rtl/scan_frame_parser.sv
`default_nettype none

`include "lidar_config.svh"

module scan_frame_parser (
    input  logic              clk,
    input  logic              rst,
    input  lidar_pkg::byte_t  rx_byte,
    input  logic              byte_valid,
    output lidar_pkg::ct_t    ct,
    output lidar_pkg::angle_t fsa,
    output lidar_pkg::angle_t lsa,
    output logic              start_frame,
    output logic              sample_valid,
    output lidar_pkg::dist_t  sample_value,
    output lidar_pkg::idx_t   sample_idx,
    output logic              frame_done
);
    import lidar_pkg::*;

    parser_state_e state;
    byte_t         sample_lo;      // Low byte held until the high byte arrives
    idx_t          next_idx;       // Index of the sample being assembled
    dist_t         value_buf;      // One entry buffer for the finished sample
    idx_t          idx_buf;
    logic          buf_full;
    logic          done_pending;   // Buffered sample is the last of the frame

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_hdr1;
            ct           <= '0;
            fsa          <= '0;
            lsa          <= '0;
            start_frame  <= 1'b0;
            sample_valid <= 1'b0;
            sample_value <= '0;
            sample_idx   <= '0;
            frame_done   <= 1'b0;
            next_idx     <= '0;
            buf_full     <= 1'b0;
            done_pending <= 1'b0;
        end else begin
            start_frame  <= 1'b0;
            sample_valid <= 1'b0;
            frame_done   <= 1'b0;

            // Drain the buffer on the second cycle after the high byte
            if (buf_full) begin
                sample_valid <= 1'b1;
                sample_value <= value_buf;
                sample_idx   <= idx_buf;
                frame_done   <= done_pending;
                buf_full     <= 1'b0;
                done_pending <= 1'b0;
            end

            if (byte_valid) begin
                case (state)
                    st_hdr1: if (rx_byte == byte_t'(`LIDAR_HDR1)) state <= st_hdr2;
                    st_hdr2: begin
                        if (rx_byte == byte_t'(`LIDAR_HDR2))
                            state <= st_ct;
                        else if (rx_byte != byte_t'(`LIDAR_HDR1))
                            state <= st_hdr1;   // Repeated 0x55 stays here
                    end
                    st_ct: begin
                        ct          <= ct_t'(rx_byte);
                        start_frame <= 1'b1;    // Clears the extrema
                        state       <= st_fsa_lo;
                    end
                    st_fsa_lo: begin
                        fsa[7:0] <= rx_byte;
                        state    <= st_fsa_hi;
                    end
                    st_fsa_hi: begin
                        fsa[15:8] <= rx_byte;
                        state     <= st_lsa_lo;
                    end
                    st_lsa_lo: begin
                        lsa[7:0] <= rx_byte;
                        state    <= st_lsa_hi;
                    end
                    st_lsa_hi: begin
                        lsa[15:8] <= rx_byte;
                        next_idx  <= '0;
                        state     <= st_sample_lo;
                    end
                    st_sample_lo: begin
                        sample_lo <= rx_byte;
                        state     <= st_sample_hi;
                    end
                    st_sample_hi: begin
                        value_buf <= {rx_byte, sample_lo};
                        idx_buf   <= next_idx;
                        buf_full  <= 1'b1;
                        if (next_idx + idx_t'(1) == idx_t'(ct)) begin   // Sample CT-1
                            done_pending <= 1'b1;
                            next_idx     <= '0;
                            state        <= st_hdr1;
                        end else begin
                            next_idx <= next_idx + idx_t'(1);
                            state    <= st_sample_lo;
                        end
                    end
                    default: state <= st_hdr1;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`default_nettype none

`include "lidar_config.svh"

module uart_rx (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx,          // Async line that idles high
    output lidar_pkg::byte_t rx_byte,
    output logic             byte_valid
);
    import lidar_pkg::*;

    localparam int CNT_W = $clog2(`LIDAR_CLKS_PER_BIT);

    logic             rx_meta;
    logic             rx_sync;
    logic             receiving;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;     // Samples taken in this character
    logic [9:0]       shift_reg;   // Stop, 8 data, start
    logic [9:0]       shift_next;

    // New line sample enters at the top so the start bit ends up in bit 0
    assign shift_next = {rx_sync, shift_reg[9:1]};

    // Two flop synchronizer
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Receiver FSM with mid-bit sampling
    always_ff @(posedge clk) begin
        if (rst) begin
            receiving  <= 1'b0;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            rx_byte    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!receiving) begin
                if (!rx_sync) begin                      // Falling edge of start bit
                    receiving <= 1'b1;
                    baud_cnt  <= CNT_W'(`LIDAR_HALF_BIT); // Offset so samples land mid-bit
                    bit_cnt   <= '0;
                end
            end else if (baud_cnt == CNT_W'(`LIDAR_CLKS_PER_BIT - 1)) begin
                baud_cnt  <= '0;
                shift_reg <= shift_next;
                bit_cnt   <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd9) begin               // Stop bit sampled
                    receiving  <= 1'b0;
                    rx_byte    <= byte_t'(shift_next[8:1]);
                    byte_valid <= 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lidar_pkg.sv
`default_nettype none

package lidar_pkg;

    typedef logic [7:0]  byte_t;   // One received UART byte
    typedef logic [7:0]  ct_t;     // Samples per frame
    typedef logic [15:0] dist_t;   // Distance in mm
    typedef logic [15:0] idx_t;    // Sample position inside a frame
    typedef logic [15:0] angle_t;  // Angle in 0.01 degree
    typedef logic [15:0] alert_t;  // Near obstacle flag per index

    // Frame parser states with one per field byte
    typedef enum logic [3:0] {
        st_hdr1,       // Waiting for 0x55
        st_hdr2,       // Waiting for 0xAA
        st_ct,         // Sample count
        st_fsa_lo,
        st_fsa_hi,
        st_lsa_lo,
        st_lsa_hi,
        st_sample_lo,  // Low byte of a distance
        st_sample_hi   // High byte that completes the sample
    } parser_state_e;

endpackage

`default_nettype wire

//--- include/lidar_config.svh
`ifndef LIDAR_CONFIG_SVH
`define LIDAR_CONFIG_SVH

// UART timing for a 100 MHz clock at 115200 baud
`define LIDAR_CLKS_PER_BIT 868
`define LIDAR_HALF_BIT 434

// Scan frame header bytes
`define LIDAR_HDR1 8'h55
`define LIDAR_HDR2 8'hAA

// Distances below this are near obstacles (mm)
`define LIDAR_ALERT_THRESH 1024

// Number of leading sample indices covered by the alert mask
`define LIDAR_ALERT_BITS 16

// One full turn in hundredths of a degree
`define LIDAR_FULL_CIRCLE 36000

`endif
